// File: spi_regs.f
+incdir+include
verilog/spi_regs_pkg.sv
verilog/spi_frame_if.sv
verilog/spi_frame_rx.sv
verilog/reg_bank.sv
verilog/cs_router.sv
verilog/spi_regs_top.sv
tests/spi_regs_properties.sv
tests/spi_regs_tb.sv

// File: Bender.yml
package:
  name: spi_regs

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/spi_regs_pkg.sv
      - verilog/spi_frame_if.sv
      - verilog/spi_frame_rx.sv
      - verilog/reg_bank.sv
      - verilog/cs_router.sv
      - verilog/spi_regs_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/spi_regs_properties.sv
      - tests/spi_regs_tb.sv

// File: tests/spi_regs_tb.sv
`default_nettype none

`include "spi_regs_config.svh"

module spi_regs_tb;

  // expected state after a frame, plus what the chip selects do during it
  typedef struct packed {
    logic [7:0]              led;
    logic [7:0]              mux;
    spi_regs_pkg::dac_ctrl_t dac;
    logic                    err;
    logic [1:0]              cs_low;
  } model_t;

  localparam int SS_TIMEOUT    = 20;
  localparam int FRAME_TIMEOUT = 400;

  logic       cs;
  logic       rst;
  logic       spi_sclk;
  logic       spi_ss;
  logic       spi_mosi;
  logic       special_n;
  logic [1:0] led;
  logic       dac_ldac;
  logic       dac_rst;
  logic       dac_uni_bip_a;
  logic       dac_uni_bip_b;
  logic       adc03_cs;
  logic       dac_spi_cs;
  logic       frame_error;

  int     seed;
  int     checks;
  int     errors;
  int     test_errors;
  model_t model;

  spi_regs_top dut (.*);

  always #10 cs = ~cs;

  // reference model, one frame in, next register state out
  function automatic model_t next_model(input model_t cur, input logic [31:0] bits,
                                        input int nbits, input logic spec_n);
    model_t nxt;
    nxt = cur;
    nxt.err = !spec_n && nbits != 0 && nbits != `FRAME_BITS;
    // chip selects follow the selection loaded before this frame
    nxt.cs_low = 2'b11;
    if (spec_n && cur.mux == 8'(spi_regs_pkg::SEL_ADC03))
      nxt.cs_low = 2'b01;
    else if (spec_n && cur.mux == 8'(spi_regs_pkg::SEL_DAC))
      nxt.cs_low = 2'b10;
    if (!spec_n && nbits == `FRAME_BITS)
    begin
      case (bits[15:8])
        spi_regs_pkg::ADDR_LED: nxt.led = bits[7:0];
        spi_regs_pkg::ADDR_MUX: nxt.mux = bits[7:0];
        spi_regs_pkg::ADDR_DAC: nxt.dac = spi_regs_pkg::dac_ctrl_t'(bits[3:0]);
        default: ;
      endcase
    end
    return nxt;
  endfunction

  task automatic check_led(input logic [1:0] exp);
    checks++;
    if (led !== exp)
    begin
      $display("FAILED t=%0t led expected %b got %b", $time, exp, led);
      test_errors++;
    end
  endtask

  task automatic check_dac(input spi_regs_pkg::dac_ctrl_t exp);
    spi_regs_pkg::dac_ctrl_t got;
    got = {dac_ldac, dac_rst, dac_uni_bip_a, dac_uni_bip_b};
    checks++;
    if (got !== exp)
    begin
      $display("FAILED t=%0t dac_ctrl expected %b got %b", $time, exp, got);
      test_errors++;
    end
  endtask

  // bit 1 is adc03_cs, bit 0 is dac_spi_cs
  task automatic check_cs(input logic [1:0] exp);
    checks++;
    if ({adc03_cs, dac_spi_cs} !== exp)
    begin
      $display("FAILED t=%0t adc03_cs,dac_spi_cs expected %b got %b", $time, exp,
               {adc03_cs, dac_spi_cs});
      test_errors++;
    end
  endtask

  task automatic check_error(input logic exp);
    checks++;
    if (frame_error !== exp)
    begin
      $display("FAILED t=%0t frame_error expected %b got %b", $time, exp, frame_error);
      test_errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, test_errors);
    errors += test_errors;
    test_errors = 0;
  endtask

  // inputs change a little after the rising edge
  task automatic tick(input int n);
    repeat (n) @(posedge cs);
    #2;
  endtask

  // msb first, data set up while sclk low, receiver takes it on the fall
  task automatic drive_frame(input logic [31:0] bits, input int nbits, input logic spec_n);
    tick(1);
    special_n = spec_n;
    tick(2);
    spi_ss = 1'b0;
    tick(2);
    for (int i = nbits - 1; i >= 0; i--)
    begin
      spi_mosi = bits[i];
      tick(2);
      spi_sclk = 1'b1;
      tick(4);
      spi_sclk = 1'b0;
      tick(2);
    end
    spi_ss = 1'b1;
    // special_n has to outlast the receiver's view of ss rising
    tick(8);
    special_n = 1'b1;
  endtask

  // watches one frame on the pins and compares against the model
  task automatic check_frame(input model_t exp);
    int n;
    n = 0;
    @(posedge cs);
    #5;
    while (spi_ss && n < SS_TIMEOUT)
    begin
      @(posedge cs);
      #5;
      n++;
    end
    if (spi_ss)
      abort_run("spi_ss never went low for the frame");
    else
    begin
      n = 0;
      // chip selects must not move inside the frame
      while (!spi_ss && n < FRAME_TIMEOUT)
      begin
        check_cs(exp.cs_low);
        @(posedge cs);
        #5;
        n++;
      end
      if (!spi_ss)
        abort_run("spi_ss stuck low past the end of the frame");
      else
      begin
        check_cs(2'b11);
        // registers and frame_error settle 4 cycles after the ss pin rises
        repeat (4) @(posedge cs);
        #5;
        check_led(exp.led[1:0]);
        check_dac(exp.dac);
        check_error(exp.err);
        // error is a single cycle pulse
        @(posedge cs);
        #5;
        check_error(1'b0);
      end
    end
  endtask

  task automatic run_frame(input logic [31:0] bits, input int nbits, input logic spec_n);
    model_t exp;
    exp = next_model(model, bits, nbits, spec_n);
    fork
      drive_frame(bits, nbits, spec_n);
      check_frame(exp);
    join
    model = exp;
  endtask

  initial
  begin
    logic [7:0] sels [3];
    cs          = 1'b0;
    rst         = 1'b1;
    spi_sclk    = 1'b0;
    spi_ss      = 1'b1;
    spi_mosi    = 1'b0;
    special_n   = 1'b1;
    seed        = 32'h9c78;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    sels[0]     = 8'(spi_regs_pkg::SEL_ADC03);
    sels[1]     = 8'(spi_regs_pkg::SEL_DAC);
    sels[2]     = 8'(spi_regs_pkg::SEL_NONE);
    model.led    = `LED_RESET;
    model.mux    = 8'(spi_regs_pkg::SEL_NONE);
    model.dac    = spi_regs_pkg::dac_ctrl_t'(`DAC_CTRL_RESET);
    model.err    = 1'b0;
    model.cs_low = 2'b11;
    repeat (5) @(posedge cs);
    #2;
    rst = 1'b0;
    tick(1);
    check_led(model.led[1:0]);
    check_dac(model.dac);
    check_cs(2'b11);
    check_error(1'b0);
    end_test("reset values");
    // alternate led and dac writes with random values
    for (int i = 0; i < 8; i++)
      run_frame({16'h0, (i % 2) ? 8'(spi_regs_pkg::ADDR_DAC) : 8'(spi_regs_pkg::ADDR_LED),
                 8'($random(seed))}, `FRAME_BITS, 1'b0);
    end_test("random led and dac writes");
    // bad lengths aimed at live registers with fresh values
    // the 17 bit frame leaves a zero in the low bit so the 15 bit one lands on the dac address
    run_frame({15'h0, 1'b1, 8'(spi_regs_pkg::ADDR_LED), ~model.led[7:1], 1'b0},
              `FRAME_BITS + 1, 1'b0);
    run_frame({17'h0, 7'(spi_regs_pkg::ADDR_DAC), 4'h0, 4'(~model.dac)},
              `FRAME_BITS - 1, 1'b0);
    end_test("bad frame length");
    run_frame({16'h0, 8'h00, 8'($random(seed))}, `FRAME_BITS, 1'b0);
    run_frame({16'h0, 8'h06, 8'($random(seed))}, `FRAME_BITS, 1'b0);
    run_frame({16'h0, 8'h0a, 8'($random(seed))}, `FRAME_BITS, 1'b0);
    run_frame({16'h0, 8'hff, 8'($random(seed))}, `FRAME_BITS, 1'b0);
    end_test("unknown addresses");
    // peripheral frame then an fpga frame for each selection
    for (int i = 0; i < 3; i++)
    begin
      run_frame({16'h0, 8'(spi_regs_pkg::ADDR_MUX), sels[i]}, `FRAME_BITS, 1'b0);
      run_frame($random(seed), `FRAME_BITS, 1'b1);
      run_frame({16'h0, 8'(spi_regs_pkg::ADDR_LED), 8'($random(seed))}, `FRAME_BITS, 1'b0);
    end
    end_test("chip select routing");
    // new selection takes effect on the very next peripheral frame
    run_frame({16'h0, 8'(spi_regs_pkg::ADDR_MUX), sels[1]}, `FRAME_BITS, 1'b0);
    run_frame($random(seed), `FRAME_BITS, 1'b1);
    run_frame({16'h0, 8'(spi_regs_pkg::ADDR_MUX), 8'h33}, `FRAME_BITS, 1'b0);
    run_frame($random(seed), `FRAME_BITS, 1'b1);
    run_frame({16'h0, 8'(spi_regs_pkg::ADDR_MUX), sels[0]}, `FRAME_BITS, 1'b0);
    run_frame($random(seed), 8, 1'b1);
    end_test("selection between frames");
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/spi_regs_properties.sv
`default_nettype none

module spi_regs_properties (
  input logic                      cs,
  input logic                      rst,
  input logic                      special_n,
  input logic                      adc03_cs,
  input logic                      dac_spi_cs,
  input logic                      frame_error,
  input logic [7:0]                led_reg,
  input logic [7:0]                mux_value,
  input spi_regs_pkg::dac_ctrl_t   dac_ctrl,
  input spi_regs_pkg::rx_state_e   rx_state
);

  // at most one peripheral selected
  one_cs_low: assert property (@(posedge cs) disable iff (rst)
    adc03_cs || dac_spi_cs)
    else $error("both peripheral chip selects low");

  // fpga frames never reach a peripheral
  cs_idle_fpga: assert property (@(posedge cs) disable iff (rst)
    !special_n |-> adc03_cs && dac_spi_cs)
    else $error("peripheral chip select low during an fpga frame");

  // a bad frame writes nothing
  error_no_write: assert property (@(posedge cs) disable iff (rst)
    frame_error |-> $stable(led_reg) && $stable(mux_value) && $stable(dac_ctrl))
    else $error("register changed together with frame_error");

  // registers only move right after the receiver ends a frame
  write_after_end: assert property (@(posedge cs) disable iff (rst)
    !($stable(led_reg) && $stable(mux_value) && $stable(dac_ctrl))
      |-> $past(rx_state) == spi_regs_pkg::RX_END)
    else $error("register changed outside the end of a frame");

endmodule

bind spi_regs_top spi_regs_properties props (
  .cs          (cs),
  .rst         (rst),
  .special_n   (special_n),
  .adc03_cs    (adc03_cs),
  .dac_spi_cs  (dac_spi_cs),
  .frame_error (frame_error),
  .led_reg     (led_reg),
  .mux_value   (mux_value),
  .dac_ctrl    (dac_ctrl),
  .rx_state    (u_frame_rx.state)
);

`default_nettype wire

// File: verilog/spi_regs_top.sv
`default_nettype none

module spi_regs_top (
  input  logic       cs,
  input  logic       rst,
  input  logic       spi_sclk,
  input  logic       spi_ss,
  input  logic       spi_mosi,
  input  logic       special_n,
  output logic [1:0] led,
  output logic       dac_ldac,
  output logic       dac_rst,
  output logic       dac_uni_bip_a,
  output logic       dac_uni_bip_b,
  output logic       adc03_cs,
  output logic       dac_spi_cs,
  output logic       frame_error
);

  logic [7:0]              led_reg;
  logic [7:0]              mux_value;
  spi_regs_pkg::dac_ctrl_t dac_ctrl;

  // finished frames, receiver to bank
  spi_frame_if frame_bus ();

  spi_frame_rx u_frame_rx (
    .cs        (cs),
    .rst       (rst),
    .spi_sclk  (spi_sclk),
    .spi_ss    (spi_ss),
    .spi_mosi  (spi_mosi),
    .special_n (special_n),
    .frame     (frame_bus.rx)
  );

  reg_bank u_reg_bank (
    .cs          (cs),
    .rst         (rst),
    .frame       (frame_bus.bank),
    .led_reg     (led_reg),
    .mux_value   (mux_value),
    .dac_ctrl    (dac_ctrl),
    .frame_error (frame_error)
  );

  cs_router u_cs_router (
    .cs         (cs),
    .rst        (rst),
    .spi_ss     (spi_ss),
    .special_n  (special_n),
    .mux_value  (mux_value),
    .adc03_cs   (adc03_cs),
    .dac_spi_cs (dac_spi_cs)
  );

  // board has two leds
  assign led = led_reg[1:0];

  // dac pins
  assign dac_ldac      = dac_ctrl.ldac;
  assign dac_rst       = dac_ctrl.rst;
  assign dac_uni_bip_a = dac_ctrl.uni_bip_a;
  assign dac_uni_bip_b = dac_ctrl.uni_bip_b;

endmodule

`default_nettype wire

// File: verilog/cs_router.sv
`default_nettype none

module cs_router (
  input  logic       cs,
  input  logic       rst,
  input  logic       spi_ss,
  input  logic       special_n,
  input  logic [7:0] mux_value,
  output logic       adc03_cs,
  output logic       dac_spi_cs
);

  logic [1:0]             ss_sync;
  spi_regs_pkg::mux_sel_e sel;

  // selection follows the mux register only while ss is idle
  // so a frame is never cut over to another chip
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      ss_sync <= 2'b11;
      sel     <= spi_regs_pkg::SEL_NONE;
    end
    else
    begin
      ss_sync <= {ss_sync[0], spi_ss};
      if (ss_sync[1])
        sel <= spi_regs_pkg::mux_sel_e'(mux_value);
    end
  end

  // raw ss straight through, any spi mode works
  always_comb
  begin
    adc03_cs   = 1'b1;
    dac_spi_cs = 1'b1;
    if (special_n)
    begin
      case (sel)
        spi_regs_pkg::SEL_ADC03: adc03_cs   = spi_ss;
        spi_regs_pkg::SEL_DAC:   dac_spi_cs = spi_ss;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/reg_bank.sv
`default_nettype none

`include "spi_regs_config.svh"

module reg_bank (
  input  logic                    cs,
  input  logic                    rst,
  spi_frame_if.bank               frame,
  output logic [7:0]              led_reg,
  output logic [7:0]              mux_value,
  output spi_regs_pkg::dac_ctrl_t dac_ctrl,
  output logic                    frame_error
);

  spi_regs_pkg::reg_addr_e addr;

  // address from the frame high byte
  assign addr = spi_regs_pkg::reg_addr_e'(frame.addr);

  // led register
  always_ff @(posedge cs)
  begin
    if (rst)
      led_reg <= `LED_RESET;
    else if (frame.valid && addr == spi_regs_pkg::ADDR_LED)
      led_reg <= frame.data;
  end

  // chip select mux
  // router picks it up only between frames
  always_ff @(posedge cs)
  begin
    if (rst)
      mux_value <= 8'(spi_regs_pkg::SEL_NONE);
    else if (frame.valid && addr == spi_regs_pkg::ADDR_MUX)
      mux_value <= frame.data;
  end

  // dac control
  // own register so the mcu can toggle reset without bit masking
  always_ff @(posedge cs)
  begin
    if (rst)
      dac_ctrl <= spi_regs_pkg::dac_ctrl_t'(`DAC_CTRL_RESET);
    else if (frame.valid && addr == spi_regs_pkg::ADDR_DAC)
      dac_ctrl <= spi_regs_pkg::dac_ctrl_t'(frame.data[3:0]);
  end

  // bad length seen by the receiver
  // never in the same cycle as a write
  always_ff @(posedge cs)
  begin
    if (rst)
      frame_error <= 1'b0;
    else
      frame_error <= frame.length_error;
  end

endmodule

`default_nettype wire

// File: verilog/spi_frame_rx.sv
`default_nettype none

`include "spi_regs_config.svh"

module spi_frame_rx (
  input  logic    cs,
  input  logic    rst,
  input  logic    spi_sclk,
  input  logic    spi_ss,
  input  logic    spi_mosi,
  input  logic    special_n,
  spi_frame_if.rx frame
);

  // one spare bit so 17 bit frames still read as wrong
  localparam int CNT_W = $clog2(`FRAME_BITS + 1) + 1;
  localparam logic [CNT_W-1:0] CNT_MAX = '1;
  localparam logic [CNT_W-1:0] CNT_FRAME = CNT_W'(`FRAME_BITS);

  logic [`SYNC_STAGES-1:0] sclk_sync;
  logic [`SYNC_STAGES-1:0] ss_sync;
  logic [`SYNC_STAGES-1:0] mosi_sync;
  logic [`SYNC_STAGES-1:0] special_sync;

  logic sclk_s;
  logic ss_s;
  logic mosi_s;
  logic special_s;
  logic sclk_d;
  logic ss_d;
  logic sclk_fall;
  logic ss_rise;
  logic bit_en;

  spi_regs_pkg::rx_state_e state;
  logic [CNT_W-1:0]        bit_cnt;
  logic [`FRAME_BITS-1:0]  shreg;
  logic                    frame_valid;
  logic                    frame_len_err;

  // pin synchronizers
  // ss and special_n idle high so they reset high
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      sclk_sync    <= '1;
      ss_sync      <= '1;
      special_sync <= '1;
      sclk_d       <= 1'b1;
      ss_d         <= 1'b1;
    end
    else
    begin
      sclk_sync    <= {sclk_sync[`SYNC_STAGES-2:0], spi_sclk};
      ss_sync      <= {ss_sync[`SYNC_STAGES-2:0], spi_ss};
      special_sync <= {special_sync[`SYNC_STAGES-2:0], special_n};
      sclk_d       <= sclk_s;
      ss_d         <= ss_s;
    end
  end

  // data pin, same latency as sclk
  always_ff @(posedge cs)
  begin
    mosi_sync <= {mosi_sync[`SYNC_STAGES-2:0], spi_mosi};
  end

  assign sclk_s    = sclk_sync[`SYNC_STAGES-1];
  assign ss_s      = ss_sync[`SYNC_STAGES-1];
  assign mosi_s    = mosi_sync[`SYNC_STAGES-1];
  assign special_s = special_sync[`SYNC_STAGES-1];

  // edges one cycle behind the synchronizer
  assign sclk_fall = sclk_d && !sclk_s;
  assign ss_rise   = !ss_d && ss_s;

  // only fpga frames shift, peripheral traffic is ignored
  assign bit_en = sclk_fall && !ss_s && !special_s;

  // msb first
  always_ff @(posedge cs)
  begin
    if (bit_en)
      shreg <= {shreg[`FRAME_BITS-2:0], mosi_s};
  end

  // saturating bit counter, cleared once the frame is done
  always_ff @(posedge cs)
  begin
    if (rst || state == spi_regs_pkg::RX_END)
      bit_cnt <= '0;
    else if (bit_en && bit_cnt != CNT_MAX)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // frame fsm
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      state         <= spi_regs_pkg::RX_IDLE;
      frame_valid   <= 1'b0;
      frame_len_err <= 1'b0;
    end
    else
    begin
      frame_valid   <= 1'b0;
      frame_len_err <= 1'b0;
      case (state)
        spi_regs_pkg::RX_IDLE:
        begin
          if (!ss_s)
            state <= spi_regs_pkg::RX_SHIFT;
        end
        spi_regs_pkg::RX_SHIFT:
        begin
          // check the length before handing the frame on
          if (ss_rise)
          begin
            state         <= spi_regs_pkg::RX_END;
            frame_valid   <= !special_s && bit_cnt == CNT_FRAME;
            frame_len_err <= !special_s && bit_cnt != '0 && bit_cnt != CNT_FRAME;
          end
        end
        default:
          state <= spi_regs_pkg::RX_IDLE;
      endcase
    end
  end

  assign frame.valid        = frame_valid;
  assign frame.length_error = frame_len_err;
  assign frame.addr         = shreg[`FRAME_BITS-1 -: 8];
  assign frame.data         = shreg[7:0];

endmodule

`default_nettype wire

// File: verilog/spi_frame_if.sv
`default_nettype none

interface spi_frame_if;

  // one cycle strobe for a good frame
  logic       valid;
  // address and value, only meaningful with valid
  logic [7:0] addr;
  logic [7:0] data;
  // one cycle strobe for a frame of the wrong length
  logic       length_error;

  // receiver side
  modport rx (
    output valid,
    output addr,
    output data,
    output length_error
  );

  // register bank side, no back-pressure
  modport bank (
    input valid,
    input addr,
    input data,
    input length_error
  );

endinterface

`default_nettype wire

// File: verilog/spi_regs_pkg.sv
`default_nettype none

package spi_regs_pkg;

  // register addresses in the frame high byte
  typedef enum logic [7:0] {
    ADDR_LED = 8'd7,
    ADDR_MUX = 8'd8,
    ADDR_DAC = 8'd9
  } reg_addr_e;

  // chip select mux values
  // anything else routes to no peripheral
  typedef enum logic [7:0] {
    SEL_NONE  = 8'd0,
    SEL_ADC03 = 8'd1,
    SEL_DAC   = 8'd2
  } mux_sel_e;

  // frame receiver states
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_SHIFT = 2'd1,
    RX_END   = 2'd2
  } rx_state_e;

  // dac control pins, msb first
  typedef struct packed {
    logic ldac;
    logic rst;
    logic uni_bip_a;
    logic uni_bip_b;
  } dac_ctrl_t;

endpackage

`default_nettype wire

// File: include/spi_regs_config.svh
`ifndef SPI_REGS_CONFIG_SVH
`define SPI_REGS_CONFIG_SVH

// bits in one fpga frame
// high byte is the register address and low byte is the value
`define FRAME_BITS 16

// flops on each spi pin before the logic sees it
`define SYNC_STAGES 2

// led register after reset
`define LED_RESET 8'h00

// dac control after reset
// order is ldac rst uni_bip_a uni_bip_b
// keeps the dac held in reset until the mcu releases it
`define DAC_CTRL_RESET 4'b0100

`endif
